// File: usb_tx_testdata.txt
# name kind(0 DATA0, 1 ACK, 2 NAK) len stall(0 none, 1 command first, 2 overfill)
# then len payload bytes in hex, which may run over several lines
ack_hs 1 0 0
nak_hs 2 0 0
data_short 0 4 0 01 02 03 04
data_zero 0 0 0
data_alt64 0 64 2
55 AA 55 AA 55 AA 55 AA 55 AA 55 AA 55 AA 55 AA
55 AA 55 AA 55 AA 55 AA 55 AA 55 AA 55 AA 55 AA
55 AA 55 AA 55 AA 55 AA 55 AA 55 AA 55 AA 55 AA
55 AA 55 AA 55 AA 55 AA 55 AA 55 AA 55 AA 55 AA
data_wait 0 8 1 DE AD BE EF 00 11 22 33
ack_again 1 0 0

// File: filelist.f
usb_pkg.sv
tx_fifo.sv
usb_crc16.sv
tx_packet_ctrl.sv
nrzi_serializer.sv
usb_tx_top.sv
usb_tx_props.sv
tb_usb_tx.sv

// File: run.sh
#!/bin/sh
# Build and run the transmitter testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_usb_tx -f filelist.f -o sim_usb_tx
out=$(./obj_dir/sim_usb_tx)
echo "$out"
echo "$out" | grep -q "^TB PASSED$"

// File: tb_usb_tx.sv
/*
  Testbench for the USB transmitter: reads test data, writes payload,
  issues commands, decodes the NRZI line and checks the bytes and EOP
*/

`timescale 1ns/100ps

module tb_usb_tx;

  localparam int BIT_CLKS   = 4;
  localparam int FIFO_DEPTH = 64;
  localparam int MAX_TESTS  = 16;
  // Extra byte offered to a full buffer
  localparam usb_pkg::byte_t TAIL_BYTE = 8'h3C;

  logic               tb_clk;
  logic               arst_n;
  logic               in_valid;
  usb_pkg::byte_t     in_data;
  logic               in_ready;
  logic               cmd_valid;
  usb_pkg::pkt_kind_t cmd_kind;
  usb_pkg::pkt_len_t  cmd_len;
  logic               cmd_ready;
  logic               dplus;
  logic               dminus;
  logic               d_mode;

  // Test table from the data file
  string          t_name [MAX_TESTS];
  int             t_kind [MAX_TESTS];
  int             t_len  [MAX_TESTS];
  int             t_stall[MAX_TESTS];
  usb_pkg::byte_t t_data [MAX_TESTS][usb_pkg::MAX_PAYLOAD];
  int             n_tests;

  usb_pkg::byte_t payload_q[$];
  usb_pkg::byte_t exp_q[$];
  int             errors;
  int             test_errs;
  int             n_pass;
  int             n_fail;
  int             written;
  int             cycles;
  int             cycle_limit;

  usb_tx_top #(
    .BIT_CLKS  (BIT_CLKS),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) uut (
    .tb_clk   (tb_clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .in_data  (in_data),
    .in_ready (in_ready),
    .cmd_valid(cmd_valid),
    .cmd_kind (cmd_kind),
    .cmd_len  (cmd_len),
    .cmd_ready(cmd_ready),
    .dplus    (dplus),
    .dminus   (dminus),
    .d_mode   (d_mode)
  );

  initial tb_clk = 1'b0;
  always #2 tb_clk = ~tb_clk;

  // Watchdog, limit set once the test table is known
  always @(posedge tb_clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Timeout: the run passed %0d cycles without finishing", cycle_limit);
      $display("TB FAILED");
      $finish;
    end
  end

  //************************************************************
  // Reporting and reference model
  //************************************************************
  task automatic report_value(input string name, input string what,
                              input int expv, input int actv);
    $display("** Error [%s] %s: expected %h, actual %h", name, what, expv, actv);
    errors++;
    test_errs++;
  endtask

  task automatic report_fault(input string name, input string msg);
    $display("Error [%s]: %s", name, msg);
    errors++;
    test_errs++;
  endtask

  // Bit-serial CRC16 over the payload stream, LSB of each byte first
  function automatic usb_pkg::crc16_t payload_crc(input usb_pkg::byte_t q[$]);
    logic [15:0] r;
    logic        b;
    r = usb_pkg::CRC16_INIT;
    for (int n = 0; n < q.size() * 8; n++) begin
      b = q[n / 8][n % 8] ^ r[0];
      r = {1'b0, r[15:1]} ^ (b ? usb_pkg::CRC16_POLY_REFL : 16'h0000);
    end
    return ~r;
  endfunction

  // SYNC, PID, then payload and CRC for data packets
  task automatic set_expected(input int kind);
    usb_pkg::crc16_t crc;
    exp_q.delete();
    exp_q.push_back(usb_pkg::SYNC_BYTE);
    case (kind)
      0:       exp_q.push_back(usb_pkg::PID_DATA0);
      1:       exp_q.push_back(usb_pkg::PID_ACK);
      default: exp_q.push_back(usb_pkg::PID_NAK);
    endcase
    if (kind == 0) begin
      foreach (payload_q[i]) exp_q.push_back(payload_q[i]);
      crc = payload_crc(payload_q);
      exp_q.push_back(crc[7:0]);
      exp_q.push_back(crc[15:8]);
    end
  endtask

  //************************************************************
  // Stimulus
  //************************************************************
  // Called on a falling edge; random idle gaps between bytes
  task automatic write_bytes(input usb_pkg::byte_t q[$]);
    int gap;
    foreach (q[i]) begin
      gap = $urandom % 3;
      repeat (gap) @(negedge tb_clk);
      in_valid = 1'b1;
      in_data  = q[i];
      #1;
      while (!in_ready) begin
        @(negedge tb_clk);
        #1;
      end
      @(negedge tb_clk);
      in_valid = 1'b0;
      written++;
    end
  endtask

  task automatic issue_cmd(input string name, input int kind, input int len,
                           input bit check_wait);
    cmd_valid = 1'b1;
    cmd_kind  = usb_pkg::pkt_kind_t'(kind);
    cmd_len   = usb_pkg::pkt_len_t'(len);
    #1;
    while (!cmd_ready) begin
      @(negedge tb_clk);
      #1;
    end
    if (check_wait && written < len) begin
      report_fault(name, "cmd_ready rose before the whole payload was buffered");
    end
    @(negedge tb_clk);
    cmd_valid = 1'b0;
  endtask

  //************************************************************
  // Line decoder
  //************************************************************
  // Samples mid-bit, counted from the edge where d_mode rises
  task automatic check_line(input string name);
    usb_pkg::byte_t got;
    logic           prev_j;
    int             nbits;
    nbits = exp_q.size() * 8;
    got   = '0;
    while (!d_mode) @(negedge tb_clk);
    repeat ((BIT_CLKS - 1) / 2) @(negedge tb_clk);
    prev_j = 1'b1;
    for (int k = 0; k < nbits; k++) begin
      if (k > 0) repeat (BIT_CLKS) @(negedge tb_clk);
      if (!d_mode || dplus == dminus) begin
        report_fault(name, $sformatf("line not in J or K during bit %0d", k));
      end
      // Same state decodes as 1, a change as 0
      got[k % 8] = (dplus == prev_j);
      prev_j     = dplus;
      if (k % 8 == 7 && got != exp_q[k / 8]) begin
        report_value(name, $sformatf("line byte %0d", k / 8), exp_q[k / 8], got);
      end
    end
    // EOP: SE0, SE0, J, then released
    for (int k = 0; k < 4; k++) begin
      repeat (BIT_CLKS) @(negedge tb_clk);
      if (k < 2 && (dplus || dminus || !d_mode)) begin
        report_fault(name, $sformatf("EOP bit %0d is not a driven SE0", k));
      end
      if (k >= 2 && (!dplus || dminus)) begin
        report_fault(name, $sformatf("line not J after SE0 (step %0d)", k));
      end
      if (k == 2 && !d_mode) report_fault(name, "d_mode low during the EOP J bit");
      if (k == 3 && d_mode) report_fault(name, "d_mode still high after EOP");
    end
  endtask

  //************************************************************
  // Test table and sequencing
  //************************************************************
  task automatic read_tests();
    int                fd;
    int                code;
    int                kind;
    int                len;
    int                stall;
    int                b;
    logic [8*16-1:0]   raw;
    logic [8*128-1:0]  line;
    n_tests = 0;
    fd = $fopen("usb_tx_testdata.txt", "r");
    if (fd == 0) begin
      $display("Error: cannot open usb_tx_testdata.txt");
      errors++;
    end else begin
      // Two header lines
      code = $fgets(line, fd);
      code = $fgets(line, fd);
      while (n_tests < MAX_TESTS &&
             $fscanf(fd, "%s %d %d %d", raw, kind, len, stall) == 4) begin
        t_name[n_tests]  = $sformatf("%0s", raw);
        t_kind[n_tests]  = kind;
        t_len[n_tests]   = len;
        t_stall[n_tests] = stall;
        for (int i = 0; i < len; i++) begin
          code = $fscanf(fd, "%h", b);
          t_data[n_tests][i] = usb_pkg::byte_t'(b);
        end
        n_tests++;
      end
      $fclose(fd);
    end
  endtask

  task automatic run_test(input int i);
    usb_pkg::byte_t wr_q[$];
    string          name;
    name      = t_name[i];
    test_errs = 0;
    written   = 0;
    payload_q.delete();
    for (int j = 0; j < t_len[i]; j++) payload_q.push_back(t_data[i][j]);
    set_expected(t_kind[i]);
    if (t_stall[i] == 1) begin
      // Command first, bytes arrive while it waits
      fork
        issue_cmd(name, t_kind[i], t_len[i], 1'b1);
        write_bytes(payload_q);
        check_line(name);
      join
    end else if (t_stall[i] == 2) begin
      write_bytes(payload_q);
      wr_q.push_back(TAIL_BYTE);
      fork
        write_bytes(wr_q);
        begin
          repeat (4) begin
            #1;
            if (in_ready) report_fault(name, "in_ready high with a full buffer");
            @(negedge tb_clk);
          end
          if (written != t_len[i]) report_fault(name, "extra byte taken by a full buffer");
          issue_cmd(name, t_kind[i], t_len[i], 1'b0);
        end
        check_line(name);
      join
      // The held byte goes out in a one-byte packet
      payload_q.delete();
      payload_q.push_back(TAIL_BYTE);
      set_expected(0);
      fork
        issue_cmd(name, 0, 1, 1'b0);
        check_line(name);
      join
    end else begin
      write_bytes(payload_q);
      fork
        issue_cmd(name, t_kind[i], t_len[i], 1'b0);
        check_line(name);
      join
    end
    if (test_errs == 0) n_pass++;
    else n_fail++;
    $display("test %-12s %s (%0d errors)", name, (test_errs == 0) ? "ok" : "failed",
             test_errs);
  endtask

  initial begin
    int limit;
    void'($urandom(32'hef6c));
    arst_n      = 1'b0;
    in_valid    = 1'b0;
    in_data     = '0;
    cmd_valid   = 1'b0;
    cmd_kind    = usb_pkg::PKT_ACK;
    cmd_len     = '0;
    errors      = 0;
    n_pass      = 0;
    n_fail      = 0;
    written     = 0;
    cycles      = 0;
    cycle_limit = 0;
    read_tests();

    // Packet bit times, write gaps and slack per test
    limit = 200;
    for (int i = 0; i < n_tests; i++) begin
      limit += (((t_kind[i] == 0) ? t_len[i] + 5 : 3) * 8 + 5) * BIT_CLKS;
      limit += t_len[i] * 4 + 40;
      if (t_stall[i] == 2) limit += (6 * 8 + 5) * BIT_CLKS + 60;
    end
    cycle_limit = limit;

    repeat (3) @(negedge tb_clk);
    arst_n = 1'b1;
    @(negedge tb_clk);

    // Idle outputs after reset
    test_errs = 0;
    if (dplus !== 1'b1) report_value("reset_state", "dplus", 1, dplus);
    if (dminus !== 1'b0) report_value("reset_state", "dminus", 0, dminus);
    if (d_mode !== 1'b0) report_value("reset_state", "d_mode", 0, d_mode);
    if (cmd_ready !== 1'b1) report_value("reset_state", "cmd_ready", 1, cmd_ready);
    if (in_ready !== 1'b1) report_value("reset_state", "in_ready", 1, in_ready);
    if (test_errs == 0) n_pass++;
    else n_fail++;
    $display("test %-12s %s (%0d errors)", "reset_state", (test_errs == 0) ? "ok" : "failed",
             test_errs);

    for (int i = 0; i < n_tests; i++) run_test(i);

    $display("%0d tests, %0d passed, %0d failed, %0d errors", n_pass + n_fail, n_pass,
             n_fail, errors);
    if (errors == 0 && n_tests > 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: usb_tx_props.sv
/*
  Line and handshake properties bound into the transmitter top level
*/

`timescale 1ns/100ps

module usb_tx_props #(
  parameter int FIFO_DEPTH = 64
) (
  input logic tb_clk,
  input logic arst_n,
  input logic dplus,
  input logic dminus,
  input logic d_mode,
  input logic cmd_ready,
  input logic in_valid,
  input logic in_ready,
  input logic fifo_pop
);

  // Buffer occupancy rebuilt from the write and pop handshakes
  int occ_q;

  always_ff @(posedge tb_clk or negedge arst_n) begin
    if (!arst_n) begin
      occ_q <= 0;
    end else begin
      occ_q <= occ_q + ((in_valid && in_ready) ? 1 : 0) - (fifo_pop ? 1 : 0);
    end
  end

  // Never SE1, and a released line idles in J
  a_line_state: assert property (@(posedge tb_clk) disable iff (!arst_n)
    !(dplus && dminus) && (d_mode || (dplus && !dminus)))
    else $error("line in SE1, or not J while released");

  // Sequencer idle means the line is released
  a_idle_released: assert property (@(posedge tb_clk) disable iff (!arst_n)
    cmd_ready |-> !d_mode) else $error("d_mode high while cmd_ready high");

  // Full buffer refuses further writes
  a_full_blocks: assert property (@(posedge tb_clk) disable iff (!arst_n)
    (occ_q >= FIFO_DEPTH) |-> !in_ready)
    else $error("in_ready high with a full buffer");

endmodule

bind usb_tx_top usb_tx_props #(
  .FIFO_DEPTH(FIFO_DEPTH)
) u_props (
  .tb_clk   (tb_clk),
  .arst_n   (arst_n),
  .dplus    (dplus),
  .dminus   (dminus),
  .d_mode   (d_mode),
  .cmd_ready(cmd_ready),
  .in_valid (in_valid),
  .in_ready (in_ready),
  .fifo_pop (fifo_pop)
);

// File: usb_tx_top.sv
/*
  USB full-speed packet transmitter top level: payload buffer,
  packet sequencer, CRC16 engine and NRZI serializer
*/

`timescale 1ns/100ps

module usb_tx_top #(
  parameter int BIT_CLKS   = 4,
  parameter int FIFO_DEPTH = 64
) (
  input  logic               tb_clk,
  input  logic               arst_n,
  // Payload byte port
  input  logic               in_valid,
  input  usb_pkg::byte_t     in_data,
  output logic               in_ready,
  // Command port
  input  logic               cmd_valid,
  input  usb_pkg::pkt_kind_t cmd_kind,
  input  usb_pkg::pkt_len_t  cmd_len,
  output logic               cmd_ready,
  // USB line
  output logic               dplus,
  output logic               dminus,
  output logic               d_mode
);

  //**********************************************************
  // Internal channels
  //**********************************************************
  logic              fifo_pop;
  usb_pkg::byte_t    fifo_data;
  usb_pkg::pkt_len_t fifo_count;
  logic              crc_clear;
  logic              crc_update;
  usb_pkg::byte_t    crc_byte;
  usb_pkg::crc16_t   crc_out;
  logic              tx_valid;
  logic              tx_ready;
  usb_pkg::byte_t    tx_byte;
  logic              eop_valid;
  logic              eop_ready;

  // Payload buffer
  tx_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_fifo (
    .tb_clk    (tb_clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .fifo_pop  (fifo_pop),
    .fifo_data (fifo_data),
    .fifo_count(fifo_count)
  );

  // Packet sequencer
  tx_packet_ctrl u_ctrl (
    .tb_clk    (tb_clk),
    .arst_n    (arst_n),
    .cmd_valid (cmd_valid),
    .cmd_kind  (cmd_kind),
    .cmd_len   (cmd_len),
    .cmd_ready (cmd_ready),
    .fifo_data (fifo_data),
    .fifo_count(fifo_count),
    .fifo_pop  (fifo_pop),
    .crc_out   (crc_out),
    .crc_clear (crc_clear),
    .crc_update(crc_update),
    .crc_byte  (crc_byte),
    .tx_ready  (tx_ready),
    .eop_ready (eop_ready),
    .tx_valid  (tx_valid),
    .tx_byte   (tx_byte),
    .eop_valid (eop_valid)
  );

  // Data field CRC
  usb_crc16 u_crc (
    .tb_clk    (tb_clk),
    .arst_n    (arst_n),
    .crc_clear (crc_clear),
    .crc_update(crc_update),
    .crc_byte  (crc_byte),
    .crc_out   (crc_out)
  );

  // Line side
  nrzi_serializer #(
    .BIT_CLKS(BIT_CLKS)
  ) u_ser (
    .tb_clk   (tb_clk),
    .arst_n   (arst_n),
    .tx_valid (tx_valid),
    .tx_byte  (tx_byte),
    .tx_ready (tx_ready),
    .eop_valid(eop_valid),
    .eop_ready(eop_ready),
    .dplus    (dplus),
    .dminus   (dminus),
    .d_mode   (d_mode)
  );

endmodule

// File: nrzi_serializer.sv
/*
  Bit timing, LSB-first shifting and NRZI line coding,
  EOP generation (SE0, SE0, J) and drive mode control
*/

`timescale 1ns/100ps

module nrzi_serializer #(
  parameter int BIT_CLKS = 4
) (
  input  logic           tb_clk,
  input  logic           arst_n,
  input  logic           tx_valid,
  input  usb_pkg::byte_t tx_byte,
  output logic           tx_ready,
  input  logic           eop_valid,
  output logic           eop_ready,
  output logic           dplus,
  output logic           dminus,
  output logic           d_mode
);

  localparam int CW = $clog2(BIT_CLKS);

  logic [CW-1:0]  bit_cnt_q;
  logic [2:0]     bit_idx_q;
  // Bit 0 is the bit now on the line
  usb_pkg::byte_t shift_q;
  logic           busy_q;
  logic           eop_act_q;
  logic [1:0]     eop_phase_q;
  // 1 means J, 0 means K
  logic           line_j_q;
  logic           se0_q;
  logic           bit_last;
  logic           byte_last;
  logic           eop_last;
  logic           load;
  logic           eop_start;

  //**********************************************************
  // Handshakes
  //**********************************************************
  assign bit_last  = (bit_cnt_q == CW'(BIT_CLKS - 1));
  assign byte_last = busy_q & bit_last & (bit_idx_q == 3'd7);
  assign eop_last  = eop_act_q & bit_last & (eop_phase_q == 2'd2);

  // Next byte lands with no gap after the final bit
  assign tx_ready  = (~busy_q & ~eop_act_q) | byte_last;
  assign eop_ready = eop_last;

  assign load      = tx_valid & tx_ready;
  assign eop_start = eop_valid & ~tx_valid & ((~busy_q & ~eop_act_q) | byte_last);

  // Line drivers
  assign dplus  = line_j_q & ~se0_q;
  assign dminus = ~line_j_q & ~se0_q;

  //**********************************************************
  // Bit engine
  //**********************************************************
  always_ff @(posedge tb_clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt_q   <= '0;
      bit_idx_q   <= '0;
      busy_q      <= 1'b0;
      eop_act_q   <= 1'b0;
      eop_phase_q <= '0;
      line_j_q    <= 1'b1;
      se0_q       <= 1'b0;
      d_mode      <= 1'b0;
    end else if (load) begin
      // First bit goes out now, a 0 toggles the line
      bit_cnt_q <= '0;
      bit_idx_q <= '0;
      busy_q    <= 1'b1;
      d_mode    <= 1'b1;
      line_j_q  <= tx_byte[0] ? line_j_q : ~line_j_q;
    end else if (eop_start) begin
      bit_cnt_q   <= '0;
      busy_q      <= 1'b0;
      eop_act_q   <= 1'b1;
      eop_phase_q <= '0;
      se0_q       <= 1'b1;
    end else if (busy_q) begin
      if (!bit_last) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end else if (byte_last) begin
        // Nothing queued, hold the line
        bit_cnt_q <= '0;
        busy_q    <= 1'b0;
      end else begin
        bit_cnt_q <= '0;
        bit_idx_q <= bit_idx_q + 1'b1;
        line_j_q  <= shift_q[1] ? line_j_q : ~line_j_q;
      end
    end else if (eop_act_q) begin
      if (!bit_last) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end else begin
        bit_cnt_q   <= '0;
        eop_phase_q <= eop_phase_q + 1'b1;
        if (eop_phase_q == 2'd1) begin
          // Closing J also restores the NRZI reference
          se0_q    <= 1'b0;
          line_j_q <= 1'b1;
        end
        if (eop_last) begin
          eop_act_q <= 1'b0;
          d_mode    <= 1'b0;
        end
      end
    end
  end

  // Shift register
  always_ff @(posedge tb_clk) begin
    if (load) begin
      shift_q <= tx_byte;
    end else if (busy_q && bit_last) begin
      shift_q <= shift_q >> 1;
    end
  end

endmodule

// File: tx_packet_ctrl.sv
/*
  Packet sequencer: takes commands, hands SYNC, PID, payload and CRC bytes
  to the serializer in order, then requests EOP
*/

`timescale 1ns/100ps

module tx_packet_ctrl (
  input  logic                tb_clk,
  input  logic                arst_n,
  // Command port
  input  logic                cmd_valid,
  input  usb_pkg::pkt_kind_t  cmd_kind,
  input  usb_pkg::pkt_len_t   cmd_len,
  output logic                cmd_ready,
  // Payload buffer
  input  usb_pkg::byte_t      fifo_data,
  input  usb_pkg::pkt_len_t   fifo_count,
  output logic                fifo_pop,
  // CRC engine
  input  usb_pkg::crc16_t     crc_out,
  output logic                crc_clear,
  output logic                crc_update,
  output usb_pkg::byte_t      crc_byte,
  // Serializer byte and EOP channels
  input  logic                tx_ready,
  input  logic                eop_ready,
  output logic                tx_valid,
  output usb_pkg::byte_t      tx_byte,
  output logic                eop_valid
);

  usb_pkg::tx_state_t state_q;
  usb_pkg::tx_state_t state_d;
  usb_pkg::pkt_kind_t kind_q;
  // Payload bytes still to hand over
  usb_pkg::pkt_len_t  rem_q;
  usb_pkg::byte_t     pid;
  logic               cmd_fire;
  logic               byte_fire;

  //**********************************************************
  // Command acceptance
  //**********************************************************
  // DATA0 waits until the whole payload sits in the buffer
  assign cmd_ready = (state_q == usb_pkg::ST_IDLE) &&
                     ((cmd_kind != usb_pkg::PKT_DATA0) || (fifo_count >= cmd_len));
  assign cmd_fire  = cmd_valid & cmd_ready;
  assign byte_fire = tx_valid & tx_ready;

  // PID for the latched command
  always_comb begin
    case (kind_q)
      usb_pkg::PKT_DATA0: pid = usb_pkg::PID_DATA0;
      usb_pkg::PKT_ACK:   pid = usb_pkg::PID_ACK;
      usb_pkg::PKT_NAK:   pid = usb_pkg::PID_NAK;
      // reserved code goes out as NAK
      default:            pid = usb_pkg::PID_NAK;
    endcase
  end

  //**********************************************************
  // Byte selection and next state
  //**********************************************************
  always_comb begin
    state_d   = state_q;
    tx_valid  = 1'b0;
    tx_byte   = usb_pkg::SYNC_BYTE;
    eop_valid = 1'b0;
    crc_clear = 1'b0;
    fifo_pop  = 1'b0;
    case (state_q)
      usb_pkg::ST_IDLE: begin
        if (cmd_fire) state_d = usb_pkg::ST_SYNC;
      end
      usb_pkg::ST_SYNC: begin
        // Fresh CRC for every packet
        crc_clear = 1'b1;
        tx_valid  = 1'b1;
        if (tx_ready) state_d = usb_pkg::ST_PID;
      end
      usb_pkg::ST_PID: begin
        tx_valid = 1'b1;
        tx_byte  = pid;
        if (tx_ready) begin
          if (kind_q != usb_pkg::PKT_DATA0) begin
            state_d = usb_pkg::ST_EOP;
          end else if (rem_q == '0) begin
            state_d = usb_pkg::ST_CRC_LO;
          end else begin
            state_d = usb_pkg::ST_DATA;
          end
        end
      end
      usb_pkg::ST_DATA: begin
        tx_valid = 1'b1;
        tx_byte  = fifo_data;
        // Head leaves the buffer on the serializer handshake
        fifo_pop = tx_ready;
        if (tx_ready && rem_q == usb_pkg::pkt_len_t'(1)) state_d = usb_pkg::ST_CRC_LO;
      end
      usb_pkg::ST_CRC_LO: begin
        tx_valid = 1'b1;
        tx_byte  = crc_out[7:0];
        if (tx_ready) state_d = usb_pkg::ST_CRC_HI;
      end
      usb_pkg::ST_CRC_HI: begin
        tx_valid = 1'b1;
        tx_byte  = crc_out[15:8];
        if (tx_ready) state_d = usb_pkg::ST_EOP;
      end
      usb_pkg::ST_EOP: begin
        // Ready comes back at the end of the J bit
        eop_valid = 1'b1;
        if (eop_ready) state_d = usb_pkg::ST_IDLE;
      end
      default: state_d = usb_pkg::ST_IDLE;
    endcase
  end

  // Payload bytes feed the CRC as they are handed over
  assign crc_update = fifo_pop;
  assign crc_byte   = fifo_data;

  //**********************************************************
  // State, command and byte counter
  //**********************************************************
  always_ff @(posedge tb_clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= usb_pkg::ST_IDLE;
      kind_q  <= usb_pkg::PKT_DATA0;
      rem_q   <= '0;
    end else begin
      state_q <= state_d;
      if (cmd_fire) begin
        kind_q <= cmd_kind;
        rem_q  <= cmd_len;
      end else if (byte_fire && state_q == usb_pkg::ST_DATA) begin
        rem_q <= rem_q - 1'b1;
      end
    end
  end

endmodule

// File: usb_crc16.sv
/*
  USB data CRC16 register, one byte per clock, LSB first,
  presented inverted for transmission
*/

`timescale 1ns/100ps

module usb_crc16 (
  input  logic            tb_clk,
  input  logic            arst_n,
  input  logic            crc_clear,
  input  logic            crc_update,
  input  usb_pkg::byte_t  crc_byte,
  output usb_pkg::crc16_t crc_out
);

  usb_pkg::crc16_t crc_q;

  // Eight serial steps of the reflected CRC folded into one clock
  function automatic usb_pkg::crc16_t next_crc(input usb_pkg::crc16_t crc,
                                               input usb_pkg::byte_t  data);
    usb_pkg::crc16_t c;
    logic            fb;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      fb = c[0] ^ data[i];
      c  = c >> 1;
      if (fb) begin
        c = c ^ usb_pkg::CRC16_POLY_REFL;
      end
    end
    return c;
  endfunction

  // Clear wins over update
  always_ff @(posedge tb_clk or negedge arst_n) begin
    if (!arst_n) begin
      crc_q <= usb_pkg::CRC16_INIT;
    end else if (crc_clear) begin
      crc_q <= usb_pkg::CRC16_INIT;
    end else if (crc_update) begin
      crc_q <= next_crc(crc_q, crc_byte);
    end
  end

  // Residue is sent complemented
  assign crc_out = ~crc_q;

endmodule

// File: tx_fifo.sv
/*
  Payload byte buffer: circular memory with valid/ready write side,
  pop-driven read side and an occupancy count toward the sequencer
*/

`timescale 1ns/100ps

module tx_fifo #(
  parameter int FIFO_DEPTH = 64
) (
  input  logic              tb_clk,
  input  logic              arst_n,
  input  logic              in_valid,
  input  usb_pkg::byte_t    in_data,
  output logic              in_ready,
  input  logic              fifo_pop,
  output usb_pkg::byte_t    fifo_data,
  output usb_pkg::pkt_len_t fifo_count
);

  localparam int AW = $clog2(FIFO_DEPTH);

  usb_pkg::byte_t mem [FIFO_DEPTH];
  logic [AW-1:0]  wr_ptr;
  logic [AW-1:0]  rd_ptr;
  // One extra bit so a full buffer is distinct from empty
  logic [AW:0]    count;
  logic           push;

  assign in_ready = (count != (AW+1)'(FIFO_DEPTH));
  assign push     = in_valid & in_ready;

  // Head byte, valid whenever count is nonzero
  assign fifo_data = mem[rd_ptr];

  // Sequencer never asks for more than a full payload
  assign fifo_count = (count > (AW+1)'(usb_pkg::MAX_PAYLOAD)) ?
                      usb_pkg::pkt_len_t'(usb_pkg::MAX_PAYLOAD) :
                      usb_pkg::pkt_len_t'(count);

  // Storage
  always_ff @(posedge tb_clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge tb_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (fifo_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, fifo_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: usb_pkg.sv
/*
  Shared USB transmit definitions: line byte, CRC and length vector types,
  command packet codes, PID and SYNC constants, CRC16 constants and the
  packet controller state enum
*/

package usb_pkg;

  //**********************************************************
  // Vector types
  //**********************************************************
  // One byte as it goes onto the line
  typedef logic [7:0]  byte_t;
  // CRC16 register and transmitted value
  typedef logic [15:0] crc16_t;
  // Packet requested on the command port
  typedef logic [1:0]  pkt_kind_t;
  // Payload byte count, 0 to 64
  typedef logic [6:0]  pkt_len_t;

  //**********************************************************
  // Command codes and line constants
  //**********************************************************
  localparam pkt_kind_t PKT_DATA0 = 2'd0;
  localparam pkt_kind_t PKT_ACK   = 2'd1;
  localparam pkt_kind_t PKT_NAK   = 2'd2;

  // Seven zeros then a one, sent LSB first
  localparam byte_t SYNC_BYTE = 8'h80;
  // PID nibble plus its complement
  localparam byte_t PID_DATA0 = 8'hC3;
  localparam byte_t PID_ACK   = 8'hD2;
  localparam byte_t PID_NAK   = 8'h5A;

  // CRC16 seed and reflected polynomial (x^16 + x^15 + x^2 + 1)
  localparam crc16_t CRC16_INIT      = 16'hFFFF;
  localparam crc16_t CRC16_POLY_REFL = 16'hA001;

  // Largest full-speed bulk payload
  localparam int MAX_PAYLOAD = 64;

  // Packet sequencer states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SYNC,
    ST_PID,
    ST_DATA,
    ST_CRC_LO,
    ST_CRC_HI,
    ST_EOP
  } tx_state_t;

endpackage
